// ==== tb.f ====
rtl/matrix_pkg.sv
rtl/ram_port_if.sv
rtl/cmd_decoder.sv
rtl/cmd_readrow.sv
rtl/frame_ram.sv
rtl/scan_counter.sv
rtl/matrix_top.sv
test/matrix_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f tb.f --top-module matrix_tb
result=$(./obj_dir/Vmatrix_tb) || true
echo "$result"
echo "$result" | grep -qF '*** TEST PASSED ***'

// ==== test/matrix_tb.sv ====
// Testbench for the framebuffer loading path with stimulus, frame model,
// reference function, compare process and timeout
`timescale 1ns/100ps

module matrix_tb import matrix_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int SEED = 79726;
    localparam int MAX_GAP = 3;
    localparam int ROW_BYTES = PIXEL_WIDTH * BYTES_PER_PIXEL;
    localparam int NUM_RANDOM_ROWS = 6;
    localparam int NUM_BAD_OPCODES = 4;
    localparam int BAD_TRAIL = 8;
    // Worst case length of every sequence, doubled for the limit
    localparam int LOAD_CYCLES = (NUM_RANDOM_ROWS + 1) * (ROW_BYTES + 3) * (MAX_GAP + 1);
    localparam int SCAN_CYCLES = ROW_BYTES * (2 * MAX_GAP + 3) + 2 * FRAME_BYTES + ROW_BYTES + 40;
    localparam int TEST_CYCLES = 10 + LOAD_CYCLES + SCAN_CYCLES + NUM_BAD_OPCODES * (BAD_TRAIL + 1);
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic       clk;
    logic       reset;
    byte_t      byte_in;
    logic       byte_valid;
    logic       scan_start;
    logic       scan_step;
    logic       load_done;
    logic       busy;
    byte_t      scan_data;
    logic       scan_valid;
    row_addr_t  scan_row;
    col_addr_t  scan_column;
    color_sel_t scan_pixel;

    byte_t model [PIXEL_HEIGHT][PIXEL_WIDTH][BYTES_PER_PIXEL];
    int scan_index = 0;
    int results_seen = 0;
    int done_pulses = 0;
    int commands_sent = 0;
    int cycle_count = 0;

    matrix_top UUT (
        .clk         (clk),
        .reset       (reset),
        .byte_in     (byte_in),
        .byte_valid  (byte_valid),
        .scan_start  (scan_start),
        .scan_step   (scan_step),
        .load_done   (load_done),
        .busy        (busy),
        .scan_data   (scan_data),
        .scan_valid  (scan_valid),
        .scan_row    (scan_row),
        .scan_column (scan_column),
        .scan_pixel  (scan_pixel)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_error(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_error($sformatf("Fail at %0t: %s expected %b, got %b",
                $time, name, expected, actual));
        end
    endtask

    task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            report_error($sformatf("Fail at %0t: %s expected %h, got %h",
                $time, name, expected, actual));
        end
    endtask

    task automatic check_addr(input row_addr_t row, input col_addr_t column,
                              input color_sel_t pixel);
        if (scan_row !== row || scan_column !== column || scan_pixel !== pixel) begin
            report_error($sformatf("Fail at %0t: scan address expected %0d/%0d/%0d, got %0d/%0d/%0d",
                $time, row, column, pixel, scan_row, scan_column, scan_pixel));
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            report_error($sformatf("Fail at %0t: %s expected %0d, got %0d",
                $time, name, expected, actual));
        end
    endtask

    function automatic byte_t expected_byte(input row_addr_t row, input col_addr_t column,
                                            input color_sel_t pixel);
        return model[row][column][pixel];
    endfunction

    // Raster count restarts while scan_start is high
    always @(negedge clk) begin
        row_addr_t row;
        col_addr_t column;
        color_sel_t pixel;
        if (load_done === 1'b1) begin
            done_pulses++;
        end
        if (scan_start === 1'b1) begin
            scan_index = 0;
            results_seen = 0;
        end else if (scan_valid === 1'b1) begin
            row = row_addr_t'(scan_index / ROW_BYTES);
            column = col_addr_t'((scan_index / BYTES_PER_PIXEL) % PIXEL_WIDTH);
            pixel = color_sel_t'(scan_index % BYTES_PER_PIXEL);
            check_addr(row, column, pixel);
            check_byte("scan_data", expected_byte(row, column, pixel), scan_data);
            scan_index = (scan_index + 1) % FRAME_BYTES;
            results_seen++;
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count > TIMEOUT_CYCLES) begin
                report_error($sformatf("Timeout after %0d cycles, the test did not finish",
                    cycle_count));
            end
        end
    end

    task automatic pause(input int max_gap);
        int gap;
        gap = int'($urandom_range(max_gap, 0));
        repeat (gap) @(negedge clk);
    endtask

    task automatic strobe_byte(input byte_t value);
        byte_in = value;
        byte_valid = 1'b1;
        @(negedge clk);
        byte_valid = 1'b0;
    endtask

    task automatic load_row(input byte_t row_byte, input int max_gap);
        row_addr_t row;
        col_addr_t column;
        color_sel_t pixel;
        byte_t value;
        row = row_addr_t'(row_byte);
        check_bit("busy", 1'b0, busy);
        strobe_byte(OP_READROW);
        check_bit("busy", 1'b1, busy);
        pause(max_gap);
        strobe_byte(row_byte);
        for (int k = 0; k < ROW_BYTES; k++) begin
            pause(max_gap);
            // Byte k counts down from the top column and colour byte
            column = col_addr_t'(PIXEL_WIDTH - 1 - k / BYTES_PER_PIXEL);
            pixel = color_sel_t'(BYTES_PER_PIXEL - 1 - k % BYTES_PER_PIXEL);
            value = byte_t'($urandom);
            model[row][column][pixel] = value;
            check_bit("load_done", 1'b0, load_done);
            check_bit("busy", 1'b1, busy);
            strobe_byte(value);
        end
        check_bit("load_done", 1'b1, load_done);
        check_bit("busy", 1'b1, busy);
        @(negedge clk);
        check_bit("load_done", 1'b0, load_done);
        check_bit("busy", 1'b0, busy);
        commands_sent++;
    endtask

    task automatic send_bad_opcodes();
        byte_t opcode;
        byte_t value;
        for (int i = 0; i < NUM_BAD_OPCODES; i++) begin
            opcode = (i == 0) ? 8'h02 : byte_t'($urandom);
            if (opcode == OP_READROW) begin
                opcode = 8'hff;
            end
            strobe_byte(opcode);
            check_bit("busy", 1'b0, busy);
            for (int j = 0; j < BAD_TRAIL; j++) begin
                // Trailing bytes must not hold the opcode themselves
                value = byte_t'($urandom);
                if (value == OP_READROW) begin
                    value = 8'h5a;
                end
                strobe_byte(value);
                check_bit("busy", 1'b0, busy);
            end
        end
    endtask

    task automatic scan_bytes(input int count, input int max_gap);
        // Two cycles long so the compare process always sees it
        scan_start = 1'b1;
        repeat (2) @(negedge clk);
        scan_start = 1'b0;
        for (int i = 0; i < count; i++) begin
            scan_step = 1'b1;
            @(negedge clk);
            scan_step = 1'b0;
            pause(max_gap);
        end
        while (results_seen < count) @(negedge clk);
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 0);
        void'($urandom(SEED));
        reset = 1'b1;
        byte_in = '0;
        byte_valid = 1'b0;
        scan_start = 1'b0;
        scan_step = 1'b0;
        for (int r = 0; r < PIXEL_HEIGHT; r++) begin
            for (int c = 0; c < PIXEL_WIDTH; c++) begin
                for (int p = 0; p < BYTES_PER_PIXEL; p++) begin
                    model[r][c][p] = '0;
                end
            end
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_bit("load_done", 1'b0, load_done);
        check_bit("busy", 1'b0, busy);
        check_bit("scan_valid", 1'b0, scan_valid);
        scan_bytes(ROW_BYTES, 0);
        // Row byte 8'h41 selects row 1 through its low five bits
        load_row(8'h41, 0);
        scan_bytes(2 * ROW_BYTES, MAX_GAP);
        send_bad_opcodes();
        scan_bytes(FRAME_BYTES, 0);
        for (int i = 0; i < NUM_RANDOM_ROWS; i++) begin
            load_row(byte_t'($urandom), MAX_GAP);
        end
        // One extra row covers the wrap back to row 0
        scan_bytes(FRAME_BYTES + ROW_BYTES, 0);
        check_count("load_done pulses", commands_sent, done_pulses);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== rtl/matrix_top.sv ====
// Framebuffer loading path: command decoder, row loader,
// frame RAM and scan counter
`timescale 1ns/100ps

module matrix_top import matrix_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  byte_t      byte_in,
    input  logic       byte_valid,
    input  logic       scan_start,
    input  logic       scan_step,
    output logic       load_done,
    output logic       busy,
    output byte_t      scan_data,
    output logic       scan_valid,
    output row_addr_t  scan_row,
    output col_addr_t  scan_column,
    output color_sel_t scan_pixel
);

    logic loader_enable;
    byte_t loader_data;

    row_addr_t rd_row;
    col_addr_t rd_column;
    color_sel_t rd_pixel;
    logic rd_en;
    byte_t rd_data;

    ram_port_if ram_port ();

    cmd_decoder u_decoder (
        .clk           (clk),
        .reset         (reset),
        .byte_in       (byte_in),
        .byte_valid    (byte_valid),
        .load_done     (load_done),
        .loader_enable (loader_enable),
        .loader_data   (loader_data),
        .busy          (busy)
    );

    cmd_readrow u_loader (
        .clk     (clk),
        .reset   (reset),
        .data_in (loader_data),
        .enable  (loader_enable),
        .ram     (ram_port.loader),
        .done    (load_done)
    );

    frame_ram u_ram (
        .clk       (clk),
        .wr        (ram_port.ram),
        .rd_row    (rd_row),
        .rd_column (rd_column),
        .rd_pixel  (rd_pixel),
        .rd_en     (rd_en),
        .rd_data   (rd_data)
    );

    scan_counter u_scan (
        .clk         (clk),
        .reset       (reset),
        .scan_start  (scan_start),
        .scan_step   (scan_step),
        .rd_row      (rd_row),
        .rd_column   (rd_column),
        .rd_pixel    (rd_pixel),
        .rd_en       (rd_en),
        .rd_data     (rd_data),
        .scan_data   (scan_data),
        .scan_valid  (scan_valid),
        .scan_row    (scan_row),
        .scan_column (scan_column),
        .scan_pixel  (scan_pixel)
    );

endmodule

// ==== rtl/scan_counter.sv ====
// Raster scan address counter with a one-stage address pipeline
// that aligns the returned address with the read data
`timescale 1ns/100ps

module scan_counter import matrix_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       scan_start,
    input  logic       scan_step,
    output row_addr_t  rd_row,
    output col_addr_t  rd_column,
    output color_sel_t rd_pixel,
    output logic       rd_en,
    input  byte_t      rd_data,
    output byte_t      scan_data,
    output logic       scan_valid,
    output row_addr_t  scan_row,
    output col_addr_t  scan_column,
    output color_sel_t scan_pixel
);

    row_addr_t cnt_row;
    col_addr_t cnt_column;
    color_sel_t cnt_pixel;

    // A step in the same cycle as scan_start is dropped
    assign rd_en = scan_step && !scan_start;
    assign rd_row = cnt_row;
    assign rd_column = cnt_column;
    assign rd_pixel = cnt_pixel;

    always_ff @(posedge clk) begin
        if (reset || scan_start) begin
            cnt_row <= '0;
            cnt_column <= '0;
            cnt_pixel <= '0;
        end else if (rd_en) begin
            if (cnt_pixel != PIX_MAX) begin
                cnt_pixel <= cnt_pixel + 1'b1;
            end else begin
                cnt_pixel <= '0;
                if (cnt_column != COL_MAX) begin
                    cnt_column <= cnt_column + 1'b1;
                end else begin
                    cnt_column <= '0;
                    cnt_row <= (cnt_row == ROW_MAX) ? '0 : cnt_row + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            scan_valid <= 1'b0;
        end else begin
            scan_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            scan_row <= cnt_row;
            scan_column <= cnt_column;
            scan_pixel <= cnt_pixel;
        end
    end

    assign scan_data = rd_data;

endmodule

// ==== rtl/frame_ram.sv ====
// Frame memory with a toggle-triggered write port and a
// registered read port
`timescale 1ns/100ps

module frame_ram import matrix_pkg::*; (
    input  logic       clk,
    ram_port_if.ram    wr,
    input  row_addr_t  rd_row,
    input  col_addr_t  rd_column,
    input  color_sel_t rd_pixel,
    input  logic       rd_en,
    output byte_t      rd_data
);

    byte_t mem [FRAME_BYTES] = '{default: 8'h00};

    logic prev_access_start;
    logic wr_fire;
    frame_addr_t wr_addr;
    frame_addr_t rd_addr;

    // Raster order: row, then column, then colour byte
    function automatic frame_addr_t byte_index(
        input row_addr_t  row,
        input col_addr_t  column,
        input color_sel_t pixel
    );
        frame_addr_t index;
        index = frame_addr_t'(row) * frame_addr_t'(PIXEL_WIDTH);
        index = (index + frame_addr_t'(column)) * frame_addr_t'(BYTES_PER_PIXEL);
        return index + frame_addr_t'(pixel);
    endfunction

    assign wr_addr = byte_index(wr.row, wr.column, wr.pixel);
    assign rd_addr = byte_index(rd_row, rd_column, rd_pixel);
    assign wr_fire = wr.write_enable && (wr.access_start != prev_access_start);

    always_ff @(posedge clk) begin
        prev_access_start <= wr.access_start;
        if (wr_fire) begin
            mem[wr_addr] <= wr.data;
        end
    end

    // A read of the address being written returns the old byte
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== rtl/cmd_readrow.sv ====
// Row loader that captures the row number, then counts columns and
// colour bytes down in reverse, writing each byte to the frame RAM
`timescale 1ns/100ps

module cmd_readrow import matrix_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  byte_t      data_in,
    input  logic       enable,
    ram_port_if.loader ram,
    output logic       done
);

    loader_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ROW_CAPTURE;
            ram.column <= '0;
            ram.pixel <= '0;
            ram.write_enable <= 1'b0;
            ram.access_start <= 1'b0;
            done <= 1'b0;
        end else begin
            case (state)
                ROW_CAPTURE: begin
                    if (enable) begin
                        state <= ROW_PRIMEMEMWRITE;
                    end
                end
                ROW_PRIMEMEMWRITE: begin
                    // First colour byte lands at the top column and colour byte
                    if (enable) begin
                        ram.column <= COL_MAX;
                        ram.pixel <= PIX_MAX;
                        ram.write_enable <= 1'b1;
                        ram.access_start <= !ram.access_start;
                        state <= READ_ROWCONTENT;
                    end
                end
                READ_ROWCONTENT: begin
                    if (enable) begin
                        ram.access_start <= !ram.access_start;
                        if (ram.pixel == '0) begin
                            ram.pixel <= PIX_MAX;
                            ram.column <= ram.column - 1'b1;
                        end else begin
                            ram.pixel <= ram.pixel - 1'b1;
                        end
                        // This byte goes to column 0, pixel 0
                        if (ram.column == '0 && ram.pixel == color_sel_t'(1)) begin
                            done <= 1'b1;
                            state <= DONE;
                        end
                    end
                end
                DONE: begin
                    // write_enable is still high for the last toggle's write edge
                    done <= 1'b0;
                    ram.write_enable <= 1'b0;
                    state <= ROW_CAPTURE;
                end
                default: begin
                    state <= ROW_CAPTURE;
                end
            endcase
        end
    end

    // Row number and colour byte payload
    always_ff @(posedge clk) begin
        if (enable) begin
            if (state == ROW_CAPTURE) begin
                ram.row <= row_addr_t'(data_in);
            end else if (state == ROW_PRIMEMEMWRITE || state == READ_ROWCONTENT) begin
                ram.data <= data_in;
            end
        end
    end

endmodule

// ==== rtl/cmd_decoder.sv ====
// Command decoder FSM that steers bytes to the row loader
`timescale 1ns/100ps

module cmd_decoder import matrix_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  byte_t byte_in,
    input  logic  byte_valid,
    input  logic  load_done,
    output logic  loader_enable,
    output byte_t loader_data,
    output logic  busy
);

    decoder_state_t state;
    decoder_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                // Unknown opcodes fall through and are dropped
                if (byte_valid && byte_in == OP_READROW) begin
                    state_next = READROW;
                end
            end
            READROW: begin
                if (load_done) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // The opcode byte itself is never forwarded
    assign loader_enable = byte_valid && (state == READROW);
    assign loader_data = byte_in;
    assign busy = (state == READROW);

endmodule

// ==== rtl/ram_port_if.sv ====
// Write-side port from the row loader to the frame RAM
`timescale 1ns/100ps

interface ram_port_if import matrix_pkg::*; ();

    row_addr_t row;
    col_addr_t column;
    color_sel_t pixel;
    byte_t data;
    logic write_enable;
    // One write per change of level
    logic access_start;

    modport loader (
        output row,
        output column,
        output pixel,
        output data,
        output write_enable,
        output access_start
    );

    modport ram (
        input row,
        input column,
        input pixel,
        input data,
        input write_enable,
        input access_start
    );

endinterface

// ==== rtl/matrix_pkg.sv ====
// Frame dimensions, command opcode, address and byte types,
// and the state encodings for the decoder and row loader
package matrix_pkg;

    localparam int PIXEL_WIDTH = 16;
    localparam int PIXEL_HEIGHT = 32;
    localparam int BYTES_PER_PIXEL = 3;

    localparam int FRAME_BYTES = PIXEL_HEIGHT * PIXEL_WIDTH * BYTES_PER_PIXEL;
    localparam int FRAME_ADDR_BITS = $clog2(FRAME_BYTES);

    typedef logic [7:0] byte_t;
    typedef logic [4:0] row_addr_t;
    typedef logic [3:0] col_addr_t;
    typedef logic [1:0] color_sel_t;
    typedef logic [FRAME_ADDR_BITS-1:0] frame_addr_t;

    localparam byte_t OP_READROW = 8'h01;

    // Countdown start and raster wrap points
    localparam row_addr_t ROW_MAX = row_addr_t'(PIXEL_HEIGHT - 1);
    localparam col_addr_t COL_MAX = col_addr_t'(PIXEL_WIDTH - 1);
    localparam color_sel_t PIX_MAX = color_sel_t'(BYTES_PER_PIXEL - 1);

    typedef enum logic [0:0] {
        IDLE,
        READROW
    } decoder_state_t;

    typedef enum logic [1:0] {
        ROW_CAPTURE,
        ROW_PRIMEMEMWRITE,
        READ_ROWCONTENT,
        DONE
    } loader_state_t;

endpackage
